// ==== sm_ctrl.f ====
+incdir+include
source/sm_types_pkg.sv
source/mem_types_pkg.sv
source/sm_lookup.sv
source/range_wiper.sv
source/sm_cmd_fsm.sv
source/sm_ctrl_top.sv
verification/sm_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sm_ctrl testbench with Verilator and runs it
# the exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sm_ctrl_tb -f sm_ctrl.f --Mdir build -o sm_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./build/sm_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// ==== verification/sm_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sm_ctrl_cfg.svh"

module sm_ctrl_tb;

    import sm_types_pkg::*;
    import mem_types_pkg::*;

    localparam int CMD_TIMEOUT  = 1000;
    localparam int BUSY_TIMEOUT = 8;
    localparam int MEM_WORDS    = 64;

    // two modules with byte ranges [lo, hi)
    localparam word_t CODE_LO [2] = '{16'h0010, 16'h0050};
    localparam word_t CODE_HI [2] = '{16'h0020, 16'h0058};
    localparam word_t DATA_LO [2] = '{16'h0040, 16'h0060};
    localparam word_t DATA_HI [2] = '{16'h0048, 16'h0070};
    localparam word_t MOD_ID  [2] = '{16'h0011, 16'h0022};

    logic      clk = 1'b0;
    logic      reset;
    logic      start;
    cmd_t      cmd;
    word_t     pc;
    word_t     r15;
    word_t     sm_prev_id;
    word_t     sm_data;
    logic      sm_data_select_valid;
    logic      sm_key_select_valid;
    addr_t     sm_data_select;
    addr_t     sm_key_select;
    sm_req_t   sm_request;
    logic      busy;
    logic      reg_write;
    word_t     dest_reg;
    word_t     reg_data_out;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    addr_t     wb_adr;
    word_t     wb_dat_o;
    byte_sel_t wb_sel;
    logic      wb_ack = 1'b0;

    logic [31:0] lcg_state = 32'hd298;
    logic [31:0] lcg_draw;
    int          ack_wait;
    logic        access_open;
    int          table_hit;
    word_t       mem [MEM_WORDS];
    word_t       exp_mem [MEM_WORDS];
    addr_t       writes [$];

    sm_ctrl_top sm_ctrl_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t fill_word(input int i);
        return 16'ha5a5 ^ (word_t'(i) * 16'h0101);
    endfunction

    // index of the module holding addr in its code or data range or -1
    function automatic int find_module(input addr_t addr);
        int idx;
        idx = -1;
        for (int m = 0; m < 2; m++)
        begin
            if ((addr >= CODE_LO[m] && addr < CODE_HI[m]) ||
                (addr >= DATA_LO[m] && addr < DATA_HI[m]))
                idx = m;
        end
        return idx;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_req(input string name, input sm_req_t got, input sm_req_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    // module table answering in the same cycle
    always @*
    begin
        table_hit            = find_module(sm_data_select);
        sm_data_select_valid = (table_hit >= 0);
        sm_key_select_valid  = (find_module(sm_key_select) >= 0);
        sm_data              = '0;
        if (table_hit >= 0)
        begin
            case (sm_request)
                REQ_PUB_START: sm_data = CODE_LO[table_hit];
                REQ_PUB_END:   sm_data = CODE_HI[table_hit];
                REQ_SEC_START: sm_data = DATA_LO[table_hit];
                REQ_SEC_END:   sm_data = DATA_HI[table_hit];
                REQ_ID:        sm_data = MOD_ID[table_hit];
                default:       sm_data = '0;
            endcase
        end
    end

    // memory slave acking after 0 to 3 wait cycles
    always @(negedge clk)
    begin
        if (reset)
        begin
            wb_ack      = 1'b0;
            access_open = 1'b0;
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] = fill_word(i);
        end
        else
        begin
            check_bit("wb_stb", wb_stb, wb_cyc);
            if (wb_ack)
            begin
                // the bus goes idle for a cycle after each ack
                check_bit("wb_cyc", wb_cyc, 1'b0);
                wb_ack = 1'b0;
            end
            else if (wb_cyc && wb_stb)
            begin
                if (!access_open)
                begin
                    access_open = 1'b1;
                    lcg_draw    = lcg_next();
                    ack_wait    = int'(lcg_draw[17:16]);
                end
                if (ack_wait == 0)
                begin
                    check_bit("wb_we", wb_we, 1'b1);
                    check_bit("all bytes in wb_sel", &wb_sel, 1'b1);
                    check_word("wb_dat_o", wb_dat_o, '0);
                    if (wb_adr[15:7] != '0)
                        abort_run($sformatf("write to %h lies outside the memory model",
                                            wb_adr));
                    mem[wb_adr[6:1]] = wb_dat_o;
                    writes.push_back(wb_adr);
                    wb_ack      = 1'b1;
                    access_open = 1'b0;
                end
                else
                    ack_wait = ack_wait - 1;
            end
            else if (access_open)
                abort_run("wb_cyc dropped before the write was acknowledged");
        end
    end

    // issue one command and follow it to its result and the fall of busy
    task automatic run_command(input cmd_t c, input word_t pc_v, input word_t r15_v,
                               input word_t prev_v, input int stray_at,
                               input word_t exp_dest, input word_t exp_data,
                               input int exp_latency, input int exp_lag);
        int   n;
        int   latency;
        int   lag;
        logic seen;
        @(negedge clk);
        cmd        = c;
        pc         = pc_v;
        r15        = r15_v;
        sm_prev_id = prev_v;
        start      = 1'b1;
        seen       = 1'b0;
        latency    = 0;
        for (n = 1; n <= CMD_TIMEOUT && !seen; n++)
        begin
            @(negedge clk);
            // a stray pulse lands while the command is still running
            start = (n == stray_at);
            if (reg_write)
            begin
                seen    = 1'b1;
                latency = n - 1;
                check_word("dest_reg", dest_reg, exp_dest);
                check_word("reg_data_out", reg_data_out, exp_data);
            end
            else
                check_bit("busy", busy, 1'b1);
        end
        if (!seen)
            abort_run($sformatf("no reg_write pulse within %0d cycles", CMD_TIMEOUT));
        if (exp_latency >= 0 && latency != exp_latency)
            abort_run($sformatf("ERROR at %0t: reg_write latency is %0d, expected %0d",
                                $time, latency, exp_latency));
        seen = 1'b0;
        lag  = 0;
        for (n = 1; n <= BUSY_TIMEOUT && !seen; n++)
        begin
            @(negedge clk);
            start = 1'b0;
            check_bit("reg_write", reg_write, 1'b0);
            if (!busy)
            begin
                seen = 1'b1;
                lag  = n;
            end
        end
        start = 1'b0;
        if (!seen)
            abort_run($sformatf("busy still high %0d cycles after the result", BUSY_TIMEOUT));
        if (lag != exp_lag)
            abort_run($sformatf("ERROR at %0t: busy fell %0d cycles after reg_write, expected %0d",
                                $time, lag, exp_lag));
    endtask

    task automatic expect_wipe(input addr_t lo, input addr_t hi, ref addr_t q[$]);
        addr_t a;
        a = lo;
        while (a < hi)
        begin
            q.push_back(a);
            exp_mem[a[6:1]] = '0;
            a = a + addr_t'(`SM_ADDR_STEP);
        end
    endtask

    task automatic check_writes(input int first, input addr_t q[$]);
        check_word("write count", word_t'(writes.size() - first), word_t'(q.size()));
        for (int k = 0; k < q.size(); k++)
            check_addr($sformatf("address of write %0d", k), writes[first + k], q[k]);
    endtask

    task automatic compare_memory();
        for (int i = 0; i < MEM_WORDS; i++)
            check_word($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
    endtask

    task automatic check_after_reset();
        check_bit("busy", busy, 1'b0);
        check_bit("reg_write", reg_write, 1'b0);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_req("sm_request", sm_request, REQ_NONE);
    endtask

    task automatic identity_lookup();
        run_command(CMD_ID, 16'h0030, 16'h0044, 16'h0000, 0, `SM_DEST_RET, MOD_ID[0], 3, 1);
        run_command(CMD_ID, 16'h0030, 16'h0056, 16'h0000, 0, `SM_DEST_RET, MOD_ID[1], 3, 1);
        // pc inside a module must not matter
        run_command(CMD_ID, 16'h0014, 16'h0080, 16'h0000, 0, `SM_DEST_RET, 16'h0000, 3, 1);
    endtask

    task automatic previous_identity();
        run_command(CMD_ID_PREV, 16'h0030, 16'h0080, 16'h0bee, 0, `SM_DEST_RET, 16'h0bee, 3, 1);
        run_command(CMD_ID_PREV, 16'h0014, 16'h0044, 16'h7001, 0, `SM_DEST_RET, 16'h7001, 3, 1);
    endtask

    task automatic disable_module(input int m, input word_t pc_v);
        addr_t exp_q [$];
        int    first;
        first = writes.size();
        expect_wipe(CODE_LO[m], CODE_HI[m], exp_q);
        expect_wipe(DATA_LO[m], DATA_HI[m], exp_q);
        run_command(CMD_DISABLE, pc_v, 16'h1234, 16'h0000, 0, `SM_DEST_DISABLE, 16'h1234, -1, 2);
        check_writes(first, exp_q);
        compare_memory();
    endtask

    task automatic disable_outside();
        addr_t none [$];
        int    first;
        first = writes.size();
        run_command(CMD_DISABLE, 16'h0030, 16'h1234, 16'h0000, 0, `SM_DEST_RET, 16'h0000, 3, 1);
        check_writes(first, none);
        compare_memory();
    endtask

    task automatic start_while_busy();
        // once during the lookup and once in the idle cycle while busy is still high
        run_command(CMD_ID, 16'h0030, 16'h0012, 16'h0000, 2, `SM_DEST_RET, MOD_ID[0], 3, 1);
        run_command(CMD_ID, 16'h0030, 16'h0044, 16'h0000, 4, `SM_DEST_RET, MOD_ID[0], 3, 1);
        repeat (6)
        begin
            @(negedge clk);
            check_bit("reg_write", reg_write, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
    endtask

    initial
    begin
        reset      = 1'b1;
        start      = 1'b0;
        cmd        = CMD_ID;
        pc         = '0;
        r15        = '0;
        sm_prev_id = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            exp_mem[i] = fill_word(i);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_after_reset();
        identity_lookup();
        previous_identity();
        disable_outside();
        disable_module(0, 16'h0014);
        disable_module(1, 16'h0052);
        start_while_busy();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/sm_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_ctrl_top
(
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             start,
    input  wire sm_types_pkg::cmd_t         cmd,
    input  wire mem_types_pkg::word_t       pc,
    input  wire mem_types_pkg::word_t       r15,
    input  wire mem_types_pkg::word_t       sm_prev_id,
    input  wire mem_types_pkg::word_t       sm_data,
    input  wire                             sm_data_select_valid,
    input  wire                             sm_key_select_valid,
    output mem_types_pkg::addr_t            sm_data_select,
    output mem_types_pkg::addr_t            sm_key_select,
    output sm_types_pkg::sm_req_t           sm_request,
    output logic                            busy,
    output logic                            reg_write,
    output mem_types_pkg::word_t            dest_reg,
    output mem_types_pkg::word_t            reg_data_out,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output mem_types_pkg::addr_t            wb_adr,
    output mem_types_pkg::word_t            wb_dat_o,
    output mem_types_pkg::byte_sel_t        wb_sel,
    input  wire                             wb_ack
);

    logic sm_valid;
    logic load_base;
    logic load_limit;
    logic wipe_run;
    logic wipe_done;

    sm_lookup sm_lookup_i
    (
        .clk                  (clk),
        .reset                (reset),
        .cmd                  (cmd),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .sm_data_select       (sm_data_select),
        .sm_key_select        (sm_key_select),
        .sm_valid             (sm_valid)
    );

    sm_cmd_fsm sm_cmd_fsm_i
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cmd          (cmd),
        .r15          (r15),
        .sm_data      (sm_data),
        .sm_prev_id   (sm_prev_id),
        .sm_valid     (sm_valid),
        .wipe_done    (wipe_done),
        .sm_request   (sm_request),
        .load_base    (load_base),
        .load_limit   (load_limit),
        .wipe_run     (wipe_run),
        .busy         (busy),
        .reg_write    (reg_write),
        .dest_reg     (dest_reg),
        .reg_data_out (reg_data_out)
    );

    // range bounds come straight from the module table answer
    range_wiper range_wiper_i
    (
        .clk        (clk),
        .reset      (reset),
        .sm_data    (sm_data),
        .load_base  (load_base),
        .load_limit (load_limit),
        .wipe_run   (wipe_run),
        .wipe_done  (wipe_done),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_sel     (wb_sel),
        .wb_ack     (wb_ack)
    );

endmodule

`default_nettype wire

// ==== source/sm_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sm_ctrl_cfg.svh"

module sm_cmd_fsm
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire sm_types_pkg::cmd_t    cmd,
    input  wire mem_types_pkg::word_t  r15,
    input  wire mem_types_pkg::word_t  sm_data,
    input  wire mem_types_pkg::word_t  sm_prev_id,
    input  wire                        sm_valid,
    input  wire                        wipe_done,
    output sm_types_pkg::sm_req_t      sm_request,
    output logic                       load_base,
    output logic                       load_limit,
    output logic                       wipe_run,
    output logic                       busy,
    output logic                       reg_write,
    output mem_types_pkg::word_t       dest_reg,
    output mem_types_pkg::word_t       reg_data_out
);

    import sm_types_pkg::*;
    import mem_types_pkg::*;

    state_t state;
    state_t next_state;
    logic   check_settled;
    logic   set_result;
    word_t  dest_val;
    word_t  data_val;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (start && !busy)
                    next_state = ST_CHECK;
            end
            ST_CHECK:
            begin
                // first cycle lets sm_valid pick up this command
                if (check_settled)
                begin
                    if (!sm_valid)
                        next_state = ST_FAIL;
                    else if (cmd == CMD_DISABLE)
                        next_state = ST_CODE_START;
                    else
                        next_state = ST_SUCCESS;
                end
            end
            ST_CODE_START: next_state = ST_CODE_END;
            ST_CODE_END:   next_state = ST_CODE_WIPE;
            ST_CODE_WIPE:
            begin
                if (wipe_done)
                    next_state = ST_DATA_START;
            end
            ST_DATA_START: next_state = ST_DATA_END;
            ST_DATA_END:   next_state = ST_DATA_WIPE;
            ST_DATA_WIPE:
            begin
                if (wipe_done)
                    next_state = ST_SUCCESS;
            end
            ST_FAIL:       next_state = ST_IDLE;
            ST_SUCCESS:    next_state = (cmd == CMD_DISABLE) ? ST_WAIT : ST_IDLE;
            ST_WAIT:       next_state = ST_IDLE;
            default:       next_state = ST_IDLE;
        endcase
    end

    always_comb
    begin
        sm_request = REQ_NONE;
        load_base  = 1'b0;
        load_limit = 1'b0;
        wipe_run   = 1'b0;
        set_result = 1'b0;
        dest_val   = '0;
        data_val   = '0;
        case (state)
            ST_CODE_START:
            begin
                sm_request = REQ_PUB_START;
                load_base  = 1'b1;
            end
            ST_CODE_END:
            begin
                sm_request = REQ_PUB_END;
                load_limit = 1'b1;
            end
            ST_DATA_START:
            begin
                sm_request = REQ_SEC_START;
                load_base  = 1'b1;
            end
            ST_DATA_END:
            begin
                sm_request = REQ_SEC_END;
                load_limit = 1'b1;
            end
            ST_CODE_WIPE, ST_DATA_WIPE:
            begin
                wipe_run = 1'b1;
            end
            ST_FAIL:
            begin
                set_result = 1'b1;
                dest_val   = `SM_DEST_RET;
            end
            ST_SUCCESS:
            begin
                set_result = 1'b1;
                case (cmd)
                    CMD_ID:
                    begin
                        sm_request = REQ_ID;
                        dest_val   = `SM_DEST_RET;
                        data_val   = sm_data;
                    end
                    CMD_ID_PREV:
                    begin
                        dest_val = `SM_DEST_RET;
                        data_val = sm_prev_id;
                    end
                    default:
                    begin
                        dest_val = `SM_DEST_DISABLE;
                        data_val = r15;
                    end
                endcase
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= ST_IDLE;
            check_settled <= 1'b0;
            busy          <= 1'b0;
            reg_write     <= 1'b0;
        end
        else
        begin
            state         <= next_state;
            check_settled <= (state == ST_CHECK);
            // stays up through the result cycle and the trailing wait
            busy          <= (state != ST_IDLE) || (next_state != ST_IDLE);
            reg_write     <= set_result;
        end
    end

    always_ff @(posedge clk)
    begin
        if (set_result)
        begin
            dest_reg     <= dest_val;
            reg_data_out <= data_val;
        end
    end

endmodule

`default_nettype wire

// ==== source/range_wiper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sm_ctrl_cfg.svh"

module range_wiper
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire mem_types_pkg::word_t  sm_data,
    input  wire                        load_base,
    input  wire                        load_limit,
    input  wire                        wipe_run,
    output logic                       wipe_done,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output mem_types_pkg::addr_t       wb_adr,
    output mem_types_pkg::word_t       wb_dat_o,
    output mem_types_pkg::byte_sel_t   wb_sel,
    input  wire                        wb_ack
);

    import mem_types_pkg::*;

    addr_t wipe_addr;
    addr_t wipe_limit;
    logic  bus_active;
    logic  range_end;

    // advance only on ack so a stalled write keeps its address
    always_ff @(posedge clk)
    begin
        if (load_base)
            wipe_addr <= sm_data;
        else if (bus_active && wb_ack)
            wipe_addr <= wipe_addr + addr_t'(`SM_ADDR_STEP);
    end

    always_ff @(posedge clk)
    begin
        if (load_limit)
            wipe_limit <= sm_data;
    end

    assign range_end = (wipe_addr >= wipe_limit);

    // after an ack the bus is idle for one cycle before the next write
    always_ff @(posedge clk)
    begin
        if (reset)
            bus_active <= 1'b0;
        else if (bus_active)
        begin
            if (wb_ack)
                bus_active <= 1'b0;
        end
        else if (wipe_run && !range_end)
            bus_active <= 1'b1;
    end

    assign wb_cyc   = bus_active;
    assign wb_stb   = bus_active;
    assign wb_we    = bus_active;
    assign wb_adr   = wipe_addr;
    assign wb_dat_o = '0;
    assign wb_sel   = '1;

    assign wipe_done = wipe_run && !bus_active && range_end;

endmodule

`default_nettype wire

// ==== source/sm_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm_lookup
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire sm_types_pkg::cmd_t    cmd,
    input  wire mem_types_pkg::word_t  pc,
    input  wire mem_types_pkg::word_t  r15,
    input  wire                        sm_data_select_valid,
    input  wire                        sm_key_select_valid,
    output mem_types_pkg::addr_t       sm_data_select,
    output mem_types_pkg::addr_t       sm_key_select,
    output logic                       sm_valid
);

    import sm_types_pkg::*;

    logic valid_next;

    // identity lookup goes by r15, everything else by pc
    assign sm_data_select = (cmd == CMD_ID) ? r15 : pc;

    // the running module owns the key select
    assign sm_key_select = pc;

    always_comb
    begin
        case (cmd)
            CMD_ID:      valid_next = sm_data_select_valid;
            CMD_DISABLE: valid_next = sm_key_select_valid;
            default:     valid_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            sm_valid <= 1'b0;
        else
            sm_valid <= valid_next;
    end

endmodule

`default_nettype wire

// ==== source/mem_types_pkg.sv ====
`default_nettype none

`include "sm_ctrl_cfg.svh"

package mem_types_pkg;

    typedef logic [`SM_WORD_WIDTH-1:0] word_t;

    // byte address with words on even addresses
    typedef logic [`SM_WORD_WIDTH-1:0] addr_t;

    // one select bit per byte lane
    typedef logic [`SM_WORD_WIDTH/8-1:0] byte_sel_t;

endpackage

`default_nettype wire

// ==== source/sm_types_pkg.sv ====
`default_nettype none

package sm_types_pkg;

    // commands accepted on a start pulse
    typedef enum logic [1:0] {
        CMD_ID      = 2'd0,
        CMD_ID_PREV = 2'd1,
        CMD_DISABLE = 2'd2
    } cmd_t;

    // what the module table should put on sm_data
    typedef enum logic [2:0] {
        REQ_NONE      = 3'd0,
        REQ_PUB_START = 3'd1,
        REQ_PUB_END   = 3'd2,
        REQ_SEC_START = 3'd3,
        REQ_SEC_END   = 3'd4,
        REQ_ID        = 3'd5
    } sm_req_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CHECK,
        ST_CODE_START,
        ST_CODE_END,
        ST_CODE_WIPE,
        ST_DATA_START,
        ST_DATA_END,
        ST_DATA_WIPE,
        ST_FAIL,
        ST_SUCCESS,
        ST_WAIT
    } state_t;

endpackage

`default_nettype wire

// ==== include/sm_ctrl_cfg.svh ====
`ifndef SM_CTRL_CFG_SVH
`define SM_CTRL_CFG_SVH

// data and address word of the processor
`define SM_WORD_WIDTH 16

// byte distance between two words during a wipe
`define SM_ADDR_STEP 2

// destination codes sent along with reg_write
`define SM_DEST_RET 16'h8000
`define SM_DEST_DISABLE 16'h0001

`endif
